//--- flist.f
mips_pkg.sv
pc_unit.sv
reg_file.sv
alu.sv
cpu_fsm.sv
datapath.sv
mycpu_top.sv
tb_sram.sv
tb_mycpu.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_mycpu \
    -Mdir obj_dir -o tb_mycpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_mycpu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

//--- tb_mycpu.sv
module tb_mycpu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int prog_len = 120;
    localparam mips_pkg::word_t region_base = 32'h0000_1000;
    // the last word jumps to itself
    localparam mips_pkg::word_t loop_pc = 32'((prog_len - 1) * 4);

    logic                 clk;
    logic                 rst_n;
    logic                 inst_sram_en;
    mips_pkg::rwen_t      inst_sram_wen;
    mips_pkg::word_t      inst_sram_addr;
    mips_pkg::word_t      inst_sram_wdata;
    mips_pkg::word_t      inst_sram_rdata;
    logic                 data_sram_en;
    mips_pkg::rwen_t      data_sram_wen;
    mips_pkg::word_t      data_sram_addr;
    mips_pkg::word_t      data_sram_wdata;
    mips_pkg::word_t      data_sram_rdata;
    mips_pkg::word_t      debug_wb_pc;
    mips_pkg::rwen_t      debug_wb_rf_wen;
    mips_pkg::creg_addr_t debug_wb_rf_wnum;
    mips_pkg::word_t      debug_wb_rf_wdata;

    mips_pkg::word_t prog [256];
    mips_pkg::word_t ref_dmem [64];
    // expected writeback trace in retire order
    mips_pkg::word_t exp_pc [$];
    mips_pkg::word_t exp_data [$];
    logic [4:0]      exp_num [$];
    int              exp_gap [$];
    // cycle the final self loop is first fetched
    int              end_cyc = 0;
    logic [31:0]     rng_state = 32'd83765;
    // cycles counted from the first fetch
    int              cyc = 0;
    int              widx = 0;
    int              last_cyc = 0;

    mycpu_top #(
        .reset_pc (32'h0000_0000)
    ) mycpu_top_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    tb_sram sram_inst (
        .clk        (clk),
        .inst_en    (inst_sram_en),
        .inst_addr  (inst_sram_addr),
        .inst_rdata (inst_sram_rdata),
        .data_en    (data_sram_en),
        .data_wen   (data_sram_wen),
        .data_addr  (data_sram_addr),
        .data_wdata (data_sram_wdata),
        .data_rdata (data_sram_rdata)
    );

    always #4 clk = ~clk;

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: test %s expected %h actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // initial data word hashed from the byte address
    function automatic mips_pkg::word_t fill_word(input mips_pkg::word_t addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a3c_96e1;
    endfunction

    function automatic mips_pkg::word_t r_type(input logic [5:0] fn, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic mips_pkg::word_t i_type(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // working registers are 1 to 7
    function automatic logic [4:0] src_reg(input logic [31:0] v);
        return 5'(1 + v % 7);
    endfunction

    function automatic logic [5:0] pick_funct(input logic [31:0] v);
        logic [5:0] fn;
        case (v % 6)
            0: fn = mips_pkg::f_addu;
            1: fn = mips_pkg::f_subu;
            2: fn = mips_pkg::f_and;
            3: fn = mips_pkg::f_or;
            4: fn = mips_pkg::f_xor;
            default: fn = mips_pkg::f_slt;
        endcase
        return fn;
    endfunction

    function automatic void build_program();
        int          i;
        int          kind;
        int          span;
        logic        room;
        logic [31:0] r;
        logic [4:0]  s;
        logic [4:0]  t;
        logic [4:0]  d;
        logic [15:0] off;
        for (int k = 0; k < 256; k++) begin
            prog[k] = '0;
        end
        i = 0;
        // seed every working register first
        for (int k = 1; k < 8; k++) begin
            r = next_rand();
            prog[i] = i_type(mips_pkg::op_addiu, 5'd0, 5'(k), r[15:0]);
            i++;
        end
        while (i < prog_len - 1) begin
            r = next_rand();
            kind = int'(r[3:0]);
            s = src_reg(r >> 8);
            t = src_reg(r >> 12);
            // destination may be $0
            d = {2'b00, r[6:4]};
            // memory ops use base $0 into the data region
            off = 16'(region_base) + {8'd0, r[21:16], 2'b00};
            span = 1 + int'(r[26:25]) % 3;
            room = (i + 4 <= prog_len - 1);
            if (kind < 6) begin
                prog[i] = r_type(pick_funct(r >> 20), d, s, t);
            end else if (kind < 10) begin
                case (kind)
                    6: prog[i] = i_type(mips_pkg::op_addiu, s, d, r[31:16]);
                    7: prog[i] = i_type(mips_pkg::op_andi, s, d, r[31:16]);
                    8: prog[i] = i_type(mips_pkg::op_ori, s, d, r[31:16]);
                    default: prog[i] = i_type(mips_pkg::op_lui, 5'd0, d, r[31:16]);
                endcase
            end else if (kind < 12) begin
                prog[i] = i_type(mips_pkg::op_sw, 5'd0, t, off);
                if (i + 1 < prog_len - 1) begin
                    // read the same word straight back
                    i++;
                    prog[i] = i_type(mips_pkg::op_lw, 5'd0, src_reg(r >> 24), off);
                end
            end else if (kind == 12) begin
                prog[i] = i_type(mips_pkg::op_lw, 5'd0, d, off);
            end else if (room && kind < 15) begin
                // equal operands half the time
                if (r[24]) begin
                    t = s;
                end
                prog[i] = i_type((kind == 13) ? mips_pkg::op_beq : mips_pkg::op_bne,
                                 s, t, 16'(span));
            end else if (room) begin
                prog[i] = {mips_pkg::op_j, 26'(i + 1 + span)};
            end else begin
                prog[i] = i_type(mips_pkg::op_ori, s, d, r[31:16]);
            end
            i++;
        end
        prog[prog_len - 1] = {mips_pkg::op_j, 26'(prog_len - 1)};
    endfunction

    // instruction set model stepping one instruction at a time with no delay slot
    function automatic void run_reference();
        mips_pkg::word_t regs [32];
        mips_pkg::word_t pc;
        mips_pkg::word_t next_pc;
        mips_pkg::word_t ins;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        mips_pkg::word_t res;
        mips_pkg::word_t imm_s;
        mips_pkg::word_t addr;
        logic [4:0]      dst;
        logic            wr;
        int              t;
        int              n;
        int              last_t;
        int              steps;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        pc = '0;
        t = 0;
        last_t = 0;
        steps = 0;
        while (pc != loop_pc && steps < 4096) begin
            ins = prog[pc[9:2]];
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            imm_s = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm_s;
            next_pc = pc + 32'd4;
            dst = ins[20:16];
            wr = 1'b1;
            res = '0;
            // alu and store take 4 cycles, load 5, branch and jump 3
            n = 4;
            case (ins[31:26])
                mips_pkg::op_special: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        mips_pkg::f_addu: res = a + b;
                        mips_pkg::f_subu: res = a - b;
                        mips_pkg::f_and:  res = a & b;
                        mips_pkg::f_or:   res = a | b;
                        mips_pkg::f_xor:  res = a ^ b;
                        mips_pkg::f_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:          wr = 1'b0;
                    endcase
                end
                mips_pkg::op_addiu: res = a + imm_s;
                mips_pkg::op_andi:  res = a & {16'd0, ins[15:0]};
                mips_pkg::op_ori:   res = a | {16'd0, ins[15:0]};
                mips_pkg::op_lui:   res = {ins[15:0], 16'd0};
                mips_pkg::op_lw: begin
                    res = ref_dmem[addr[7:2]];
                    n = 5;
                end
                mips_pkg::op_sw: begin
                    ref_dmem[addr[7:2]] = b;
                    wr = 1'b0;
                end
                mips_pkg::op_beq, mips_pkg::op_bne: begin
                    wr = 1'b0;
                    n = 3;
                    if ((a == b) == (ins[31:26] == mips_pkg::op_beq)) begin
                        next_pc = next_pc + {imm_s[29:0], 2'b00};
                    end
                end
                mips_pkg::op_j: begin
                    wr = 1'b0;
                    n = 3;
                    next_pc = {next_pc[31:28], ins[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            // writeback lands on the last cycle of the instruction
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                exp_pc.push_back(pc);
                exp_num.push_back(dst);
                exp_data.push_back(res);
                exp_gap.push_back(t + n - 1 - last_t);
                last_t = t + n - 1;
            end
            t += n;
            pc = next_pc;
            steps++;
        end
        end_cyc = t;
    endfunction

    initial begin : main
        clk = 1'b0;
        rst_n = 1'b0;
        build_program();
        for (int k = 0; k < 256; k++) begin
            sram_inst.imem[k] = prog[k];
        end
        for (int k = 0; k < 64; k++) begin
            sram_inst.dmem[k] = fill_word(region_base + 32'(4 * k));
            ref_dmem[k] = fill_word(region_base + 32'(4 * k));
        end
        run_reference();
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        // all writes seen and 20 quiet cycles in the final loop
        while (!(widx == exp_pc.size() && cyc > end_cyc + 20)) begin
            @(posedge clk);
        end
        for (int k = 0; k < 64; k++) begin
            check_equal("final_dmem", ref_dmem[k], sram_inst.dmem[k]);
        end
        $display("Finished with no errors");
        $finish;
    end

    // sample mid cycle away from the rising edge
    always @(negedge clk) begin
        if (rst_n !== 1'b1) begin
            check_equal("reset_data_en", 32'd0, 32'(data_sram_en));
            check_equal("reset_rf_wen", 32'd0, 32'(debug_wb_rf_wen));
        end else begin
            if (cyc == 0) begin
                check_equal("first_fetch_en", 32'd1, 32'(inst_sram_en));
                check_equal("first_fetch_addr", 32'd0, inst_sram_addr);
            end
            // instruction port never writes
            check_equal("inst_wen", 32'd0, 32'(inst_sram_wen));
            check_equal("inst_wdata", 32'd0, inst_sram_wdata);
            // program opens with register seeds
            if (widx == 0) begin
                check_equal("early_data_en", 32'd0, 32'(data_sram_en));
            end
            if (data_sram_en) begin
                check_equal("data_region", region_base >> 8, data_sram_addr >> 8);
            end
            if (|debug_wb_rf_wen) begin
                // all four strobe bits copy the write enable
                check_equal("wb_wen", 32'hf, 32'(debug_wb_rf_wen));
                if (widx >= exp_pc.size()) begin
                    check_equal("write_count", 32'(exp_pc.size()), 32'(widx + 1));
                end else begin
                    check_equal("wb_pc", exp_pc[widx], debug_wb_pc);
                    check_equal("wb_num", 32'(exp_num[widx]), 32'(debug_wb_rf_wnum));
                    check_equal("wb_data", exp_data[widx], debug_wb_rf_wdata);
                    check_equal("wb_gap", 32'(exp_gap[widx]), 32'(cyc - last_cyc));
                    last_cyc = cyc;
                    widx++;
                end
            end
            if (cyc == end_cyc) begin
                check_equal("writes_at_loop", 32'(exp_pc.size()), 32'(widx));
            end
            // only the self loop is fetched from here on
            if (cyc >= end_cyc && inst_sram_en) begin
                check_equal("loop_pc", loop_pc, inst_sram_addr);
            end
            cyc++;
        end
    end

    // 6 cycles per instruction plus 100 spare and the reset cycles
    initial begin : watchdog
        #((prog_len * 6 + 100 + 5) * 8);
        $display("watchdog expired, the core stopped retiring instructions");
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

endmodule

//--- tb_sram.sv
module tb_sram (
    input  logic            clk,
    input  logic            inst_en,
    input  mips_pkg::word_t inst_addr,
    output mips_pkg::word_t inst_rdata,
    input  logic            data_en,
    input  mips_pkg::rwen_t data_wen,
    input  mips_pkg::word_t data_addr,
    input  mips_pkg::word_t data_wdata,
    output mips_pkg::word_t data_rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    // 256 instruction words from address 0
    mips_pkg::word_t imem [256];
    // 64 data words, region aligned to 256 bytes
    mips_pkg::word_t dmem [64];

    // read data is defined before the first fetch
    initial begin
        inst_rdata = '0;
        data_rdata = '0;
    end

    // one cycle read latency, rdata holds between reads
    always @(posedge clk) begin
        if (inst_en) begin
            inst_rdata <= imem[inst_addr[9:2]];
        end
    end

    always @(posedge clk) begin
        if (data_en) begin
            if (data_wen == 4'h0) begin
                data_rdata <= dmem[data_addr[7:2]];
            end
            // byte strobes
            for (int b = 0; b < 4; b++) begin
                if (data_wen[b]) begin
                    dmem[data_addr[7:2]][8*b +: 8] <= data_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- mycpu_top.sv
module mycpu_top #(
    parameter mips_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  logic                 clk,
    input  logic                 rst_n,

    output logic                 inst_sram_en,
    output mips_pkg::rwen_t      inst_sram_wen,
    output mips_pkg::word_t      inst_sram_addr,
    output mips_pkg::word_t      inst_sram_wdata,
    input  mips_pkg::word_t      inst_sram_rdata,

    output logic                 data_sram_en,
    output mips_pkg::rwen_t      data_sram_wen,
    output mips_pkg::word_t      data_sram_addr,
    output mips_pkg::word_t      data_sram_wdata,
    input  mips_pkg::word_t      data_sram_rdata,

    // writeback trace
    output mips_pkg::word_t      debug_wb_pc,
    output mips_pkg::rwen_t      debug_wb_rf_wen,
    output mips_pkg::creg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t      debug_wb_rf_wdata
);

    mips_pkg::m_r_t         mread;
    mips_pkg::m_w_t         mwrite;
    mips_pkg::rf_w_t        rfwrite;
    mips_pkg::cpu_state_t   state;
    mips_pkg::instr_class_t instr_class;
    mips_pkg::word_t        pc;
    mips_pkg::word_t        target;
    logic                   branch_taken;
    logic                   ir_load;
    logic                   pc_inc;
    logic                   pc_load;
    logic                   rf_we;

    pc_unit #(
        .reset_pc (reset_pc)
    ) pc_unit_inst (
        .clk,
        .rst_n,
        .pc_inc,
        .pc_load,
        .target,
        .pc
    );

    cpu_fsm cpu_fsm_inst (
        .clk,
        .rst_n,
        .instr_class,
        .branch_taken,
        .state,
        .ir_load,
        .pc_inc,
        .pc_load,
        .rf_we
    );

    datapath datapath_inst (
        .clk,
        .rst_n,
        .state,
        .ir_load,
        .rf_we,
        .pc,
        .instr        (inst_sram_rdata),
        .rd           (data_sram_rdata),
        .instr_class,
        .branch_taken,
        .target,
        .mread,
        .mwrite,
        .rfwrite,
        .wb_pc        (debug_wb_pc)
    );

    // instruction port is read only
    assign inst_sram_en    = (state == mips_pkg::s_fetch);
    assign inst_sram_wen   = 4'b0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = '0;

    // write address wins when a strobe is up
    assign data_sram_en    = mread.ren | (|mwrite.wen);
    assign data_sram_wen   = mwrite.wen;
    assign data_sram_addr  = (|mwrite.wen) ? mwrite.addr : mread.addr;
    assign data_sram_wdata = mwrite.wd;

    // $0 writes leave no pulse
    assign debug_wb_rf_wen   = {4{rfwrite.wen && (rfwrite.addr != 5'd0)}};
    assign debug_wb_rf_wnum  = rfwrite.addr;
    assign debug_wb_rf_wdata = rfwrite.wd;

endmodule

//--- datapath.sv
module datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mips_pkg::cpu_state_t   state,
    input  logic                   ir_load,
    input  logic                   rf_we,
    input  mips_pkg::word_t        pc,
    input  mips_pkg::word_t        instr,
    input  mips_pkg::word_t        rd,
    output mips_pkg::instr_class_t instr_class,
    output logic                   branch_taken,
    output mips_pkg::word_t        target,
    output mips_pkg::m_r_t         mread,
    output mips_pkg::m_w_t         mwrite,
    output mips_pkg::rf_w_t        rfwrite,
    output mips_pkg::word_t        wb_pc
);

    mips_pkg::word_t ir_q;
    mips_pkg::word_t ir_pc_q;
    mips_pkg::word_t a_q;
    mips_pkg::word_t b_q;
    mips_pkg::word_t alu_q;
    mips_pkg::word_t rf_rd1;
    mips_pkg::word_t rf_rd2;

    mips_pkg::opcode_t      opcode;
    mips_pkg::funct_t       funct;
    mips_pkg::instr_class_t cls;
    mips_pkg::alu_op_t      alu_op;
    logic                   use_imm;
    logic                   zero_ext;
    logic                   writes_reg;
    logic                   dest_rd;

    mips_pkg::word_t imm_ext;
    mips_pkg::word_t alu_b;
    mips_pkg::word_t alu_y;
    logic            alu_zero;
    mips_pkg::word_t pc_plus4;
    mips_pkg::word_t br_target;
    mips_pkg::word_t j_target;

    // ir and its pc latched as the fetched word arrives
    // ir clears to sll $0 which is a no-op
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_q <= '0;
        end else if (ir_load) begin
            ir_q <= instr;
        end
    end

    // operands read straight from the fetched word's rs and rt
    always_ff @(posedge clk) begin
        if (ir_load) begin
            ir_pc_q <= pc;
            a_q     <= rf_rd1;
            b_q     <= rf_rd2;
        end
        if (state == mips_pkg::s_exec) begin
            alu_q <= alu_y;
        end
    end

    reg_file reg_file_inst (
        .clk,
        .rst_n,
        .ra1 (instr[25:21]),
        .ra2 (instr[20:16]),
        .wr  (rfwrite),
        .rd1 (rf_rd1),
        .rd2 (rf_rd2)
    );

    assign opcode = mips_pkg::opcode_t'(ir_q[31:26]);
    assign funct  = mips_pkg::funct_t'(ir_q[5:0]);

    // unknown encodings fall through as alu no-ops
    always_comb begin
        cls        = mips_pkg::c_alu;
        alu_op     = mips_pkg::alu_add;
        use_imm    = 1'b1;
        zero_ext   = 1'b0;
        writes_reg = 1'b0;
        dest_rd    = 1'b0;
        case (opcode)
            mips_pkg::op_special: begin
                use_imm    = 1'b0;
                dest_rd    = 1'b1;
                writes_reg = 1'b1;
                case (funct)
                    mips_pkg::f_addu: alu_op = mips_pkg::alu_add;
                    mips_pkg::f_subu: alu_op = mips_pkg::alu_sub;
                    mips_pkg::f_and:  alu_op = mips_pkg::alu_and;
                    mips_pkg::f_or:   alu_op = mips_pkg::alu_or;
                    mips_pkg::f_xor:  alu_op = mips_pkg::alu_xor;
                    mips_pkg::f_slt:  alu_op = mips_pkg::alu_slt;
                    default:          writes_reg = 1'b0;
                endcase
            end
            mips_pkg::op_addiu: begin
                writes_reg = 1'b1;
            end
            mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_lui: begin
                // logical immediates are zero extended
                zero_ext   = 1'b1;
                writes_reg = 1'b1;
                if (opcode == mips_pkg::op_andi) begin
                    alu_op = mips_pkg::alu_and;
                end else if (opcode == mips_pkg::op_ori) begin
                    alu_op = mips_pkg::alu_or;
                end else begin
                    alu_op = mips_pkg::alu_lui;
                end
            end
            mips_pkg::op_lw: begin
                cls        = mips_pkg::c_load;
                writes_reg = 1'b1;
            end
            mips_pkg::op_sw: begin
                cls = mips_pkg::c_store;
            end
            mips_pkg::op_beq, mips_pkg::op_bne: begin
                // compare rs and rt by subtracting
                cls     = mips_pkg::c_branch;
                alu_op  = mips_pkg::alu_sub;
                use_imm = 1'b0;
            end
            mips_pkg::op_j: begin
                cls = mips_pkg::c_jump;
            end
            default: begin
            end
        endcase
    end

    assign imm_ext = zero_ext ? {16'd0, ir_q[15:0]} : {{16{ir_q[15]}}, ir_q[15:0]};
    assign alu_b   = use_imm ? imm_ext : b_q;

    alu alu_inst (
        .op   (alu_op),
        .a    (a_q),
        .b    (alu_b),
        .y    (alu_y),
        .zero (alu_zero)
    );

    assign instr_class  = cls;
    assign branch_taken = (cls == mips_pkg::c_branch) &&
                          ((opcode == mips_pkg::op_bne) ^ alu_zero);

    // targets relative to the instruction's own pc
    assign pc_plus4  = ir_pc_q + 32'd4;
    assign br_target = pc_plus4 + {{14{ir_q[15]}}, ir_q[15:0], 2'b00};
    assign j_target  = {pc_plus4[31:28], ir_q[25:0], 2'b00};
    assign target    = (cls == mips_pkg::c_jump) ? j_target : br_target;

    // memory requests only live in s_mem
    always_comb begin
        mread  = '0;
        mwrite = '0;
        if (state == mips_pkg::s_mem) begin
            if (cls == mips_pkg::c_load) begin
                mread.ren  = 1'b1;
                mread.addr = alu_q;
            end
            if (cls == mips_pkg::c_store) begin
                mwrite.wen  = 4'hf;
                mwrite.addr = alu_q;
                mwrite.wd   = b_q;
            end
        end
    end

    // load data comes back during s_wb
    always_comb begin
        rfwrite.wen  = rf_we && writes_reg;
        rfwrite.addr = dest_rd ? ir_q[15:11] : ir_q[20:16];
        rfwrite.wd   = (cls == mips_pkg::c_load) ? rd : alu_q;
    end

    assign wb_pc = ir_pc_q;

endmodule

//--- cpu_fsm.sv
module cpu_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mips_pkg::instr_class_t instr_class,
    input  logic                   branch_taken,
    output mips_pkg::cpu_state_t   state,
    output logic                   ir_load,
    output logic                   pc_inc,
    output logic                   pc_load,
    output logic                   rf_we
);

    mips_pkg::cpu_state_t state_q;
    mips_pkg::cpu_state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= mips_pkg::s_fetch;
        end else begin
            state_q <= state_next;
        end
    end

    always_comb begin
        state_next = state_q;
        case (state_q)
            mips_pkg::s_fetch: begin
                state_next = mips_pkg::s_decode;
            end
            mips_pkg::s_decode: begin
                state_next = mips_pkg::s_exec;
            end
            mips_pkg::s_exec: begin
                // class is known once the ir is loaded
                case (instr_class)
                    mips_pkg::c_alu: begin
                        state_next = mips_pkg::s_wb;
                    end
                    mips_pkg::c_load, mips_pkg::c_store: begin
                        state_next = mips_pkg::s_mem;
                    end
                    default: begin
                        state_next = mips_pkg::s_fetch;
                    end
                endcase
            end
            mips_pkg::s_mem: begin
                // store is done once the write is issued
                if (instr_class == mips_pkg::c_load) begin
                    state_next = mips_pkg::s_wb;
                end else begin
                    state_next = mips_pkg::s_fetch;
                end
            end
            default: begin
                state_next = mips_pkg::s_fetch;
            end
        endcase
    end

    assign state = state_q;

    // fetched word arrives in decode
    assign ir_load = (state_q == mips_pkg::s_decode);
    assign pc_inc  = (state_q == mips_pkg::s_decode);

    // no delay slot, redirect straight from exec
    assign pc_load = (state_q == mips_pkg::s_exec) &&
                     ((instr_class == mips_pkg::c_jump) ||
                      ((instr_class == mips_pkg::c_branch) && branch_taken));

    assign rf_we = (state_q == mips_pkg::s_wb);

endmodule

//--- alu.sv
module alu (
    input  mips_pkg::alu_op_t op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    output mips_pkg::word_t   y,
    output logic              zero
);

    // signed compare for slt
    logic lt;

    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            mips_pkg::alu_add: begin
                y = a + b;
            end
            mips_pkg::alu_sub: begin
                y = a - b;
            end
            mips_pkg::alu_and: begin
                y = a & b;
            end
            mips_pkg::alu_or: begin
                y = a | b;
            end
            mips_pkg::alu_xor: begin
                y = a ^ b;
            end
            mips_pkg::alu_slt: begin
                y = {31'd0, lt};
            end
            mips_pkg::alu_lui: begin
                // immediate into the upper half
                y = {b[15:0], 16'd0};
            end
            default: begin
                y = '0;
            end
        endcase
    end

    // beq and bne look at this after a subtract
    assign zero = (y == '0);

endmodule

//--- reg_file.sv
module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::creg_addr_t ra1,
    input  mips_pkg::creg_addr_t ra2,
    input  mips_pkg::rf_w_t      wr,
    output mips_pkg::word_t      rd1,
    output mips_pkg::word_t      rd2
);

    mips_pkg::word_t regs [32];

    // write at the edge, $0 stays zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.wen && (wr.addr != 5'd0)) begin
            regs[wr.addr] <= wr.wd;
        end
    end

    // combinational reads
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

//--- pc_unit.sv
module pc_unit #(
    parameter mips_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pc_inc,
    input  logic            pc_load,
    input  mips_pkg::word_t target,
    output mips_pkg::word_t pc
);

    mips_pkg::word_t pc_q;
    mips_pkg::word_t pc_next;

    // sequential successor
    mips_pkg::word_t pc_plus4;

    assign pc_plus4 = pc_q + 32'd4;

    // jump or taken branch overrides the increment
    always_comb begin
        pc_next = pc_q;
        if (pc_load) begin
            pc_next = target;
        end else if (pc_inc) begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= reset_pc;
        end else begin
            pc_q <= pc_next;
        end
    end

    // also the fetch address
    assign pc = pc_q;

endmodule

//--- mips_pkg.sv
package mips_pkg;

    // basic machine types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;
    typedef logic [3:0]  rwen_t;

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    // r-type function codes, instr[5:0]
    typedef enum logic [5:0] {
        f_addu = 6'h21,
        f_subu = 6'h23,
        f_and  = 6'h24,
        f_or   = 6'h25,
        f_xor  = 6'h26,
        f_slt  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui
    } alu_op_t;

    // one pass of these per instruction
    typedef enum logic [2:0] {
        s_fetch,
        s_decode,
        s_exec,
        s_mem,
        s_wb
    } cpu_state_t;

    // what the fsm branches on after exec
    typedef enum logic [2:0] {
        c_alu,
        c_load,
        c_store,
        c_branch,
        c_jump
    } instr_class_t;

    // data read request
    typedef struct packed {
        logic  ren;
        word_t addr;
    } m_r_t;

    // data write request, byte strobes
    typedef struct packed {
        rwen_t wen;
        word_t addr;
        word_t wd;
    } m_w_t;

    // register file write
    typedef struct packed {
        logic       wen;
        creg_addr_t addr;
        word_t      wd;
    } rf_w_t;

endpackage
